// ==== verilog/mc_wh_cfg.svh ====
// Width and reset-depth macros for the manycore-to-wormhole adapter; include before use
`ifndef MC_WH_CFG_SVH
`define MC_WH_CFG_SVH

// Manycore packet fields
`define MC_WH_ADDR_WIDTH 16
`define MC_WH_DATA_WIDTH 32
`define MC_WH_X_CORD_WIDTH 4
`define MC_WH_Y_CORD_WIDTH 4

// Wormhole link
`define MC_WH_FLIT_WIDTH 16
`define MC_WH_CORD_WIDTH 8
`define MC_WH_LEN_WIDTH 4

// Registers between reset_i and the engines
`define MC_WH_RESET_DEPTH 3

`endif

// ==== verilog/mc_wh_pkg.sv ====
// Packet and flit types shared by the adapter RTL and its testbench
`include "mc_wh_cfg.svh"

package mc_wh_pkg;

  // Forward net request, 58 bits
  typedef struct packed
  {
    logic [1:0]                         op;
    logic [`MC_WH_ADDR_WIDTH-1:0]       addr;
    logic [`MC_WH_DATA_WIDTH-1:0]       data;
    logic [`MC_WH_X_CORD_WIDTH-1:0]     src_x;
    logic [`MC_WH_Y_CORD_WIDTH-1:0]     src_y;
  } mc_fwd_packet_t;

  // Reverse net response, 34 bits
  typedef struct packed
  {
    logic [1:0]                         op;
    logic [`MC_WH_DATA_WIDTH-1:0]       data;
  } mc_rev_packet_t;

  // Header flit
  // Cord sits in the low bits, len above it, zeros at the top
  typedef struct packed
  {
    logic [`MC_WH_FLIT_WIDTH-`MC_WH_LEN_WIDTH-`MC_WH_CORD_WIDTH-1:0] pad;
    logic [`MC_WH_LEN_WIDTH-1:0]                                     len;
    logic [`MC_WH_CORD_WIDTH-1:0]                                    cord;
  } wh_header_t;

endpackage

// ==== verilog/wh_packetizer.sv ====
// Splits a strobed manycore packet into header and body flits; one instance per net
`include "mc_wh_cfg.svh"

module wh_packetizer
  #(parameter type payload_t = logic [`MC_WH_FLIT_WIDTH-1:0])
  (input  logic                         mc_clk_i
  ,input  logic                         reset_i

  // Manycore side
  ,input  logic                         v_i
  ,input  payload_t                     packet_i
  ,input  logic [`MC_WH_CORD_WIDTH-1:0] dest_cord_i

  // Wormhole side
  ,output logic                         v_o
  ,output logic [`MC_WH_FLIT_WIDTH-1:0] flit_o
  );

  localparam int payload_width_lp = $bits(payload_t);
  localparam int num_body_lp =
    (payload_width_lp + `MC_WH_FLIT_WIDTH - 1) / `MC_WH_FLIT_WIDTH;
  localparam int padded_width_lp = num_body_lp * `MC_WH_FLIT_WIDTH;
  localparam logic [`MC_WH_LEN_WIDTH-1:0] body_len_lp = num_body_lp[`MC_WH_LEN_WIDTH-1:0];

  mc_wh_pkg::wh_header_t           header;
  logic [padded_width_lp-1:0]      packet_pad;
  logic [padded_width_lp-1:0]      shift_r;
  logic [`MC_WH_LEN_WIDTH-1:0]     cnt_r;
  logic                            busy;
  logic                            v_r;
  logic [`MC_WH_FLIT_WIDTH-1:0]    flit_r;

  // Header from the destination and the fixed body length
  always_comb
  begin
    header      = '0;
    header.cord = dest_cord_i;
    header.len  = body_len_lp;
  end

  // Zero the unused top bits of the last flit
  always_comb
  begin
    packet_pad                         = '0;
    packet_pad[payload_width_lp-1:0]   = packet_i;
  end

  // Body flits still to send
  assign busy = (cnt_r != '0);

  always_ff @(posedge mc_clk_i)
  begin
    if (reset_i)
    begin
      v_r   <= 1'b0;
      cnt_r <= '0;
    end
    else if (v_i)
    begin
      v_r   <= 1'b1;
      cnt_r <= body_len_lp;
    end
    else if (busy)
    begin
      v_r   <= 1'b1;
      cnt_r <= cnt_r - 1'b1;
    end
    else
    begin
      v_r   <= 1'b0;
    end
  end

  // Flit datapath, least significant part goes first
  always_ff @(posedge mc_clk_i)
  begin
    if (v_i)
    begin
      flit_r  <= header;
      shift_r <= packet_pad;
    end
    else if (busy)
    begin
      flit_r  <= shift_r[`MC_WH_FLIT_WIDTH-1:0];
      shift_r <= shift_r >> `MC_WH_FLIT_WIDTH;
    end
  end

  assign v_o    = v_r;
  assign flit_o = flit_r;

  // Sender must not offer a packet before the last body flit goes out
  assert property (@(posedge mc_clk_i) disable iff (reset_i) v_i |-> !busy)
    else $error("wh_packetizer: packet offered while busy");

endmodule

// ==== verilog/wh_depacketizer.sv ====
// Gathers a header and body flits back into one manycore packet; one instance per net
`include "mc_wh_cfg.svh"

module wh_depacketizer
  #(parameter type payload_t = logic [`MC_WH_FLIT_WIDTH-1:0])
  (input  logic                         mc_clk_i
  ,input  logic                         reset_i

  // Wormhole side
  ,input  logic                         v_i
  ,input  logic [`MC_WH_FLIT_WIDTH-1:0] flit_i

  // Manycore side
  ,output logic                         v_o
  ,output payload_t                     packet_o
  );

  localparam int payload_width_lp = $bits(payload_t);
  localparam int num_body_lp =
    (payload_width_lp + `MC_WH_FLIT_WIDTH - 1) / `MC_WH_FLIT_WIDTH;
  localparam int padded_width_lp = num_body_lp * `MC_WH_FLIT_WIDTH;

  typedef enum logic {idle_s, body_s} state_e;

  state_e                          state_r;
  mc_wh_pkg::wh_header_t           header;
  logic [`MC_WH_LEN_WIDTH-1:0]     cnt_r;
  logic [padded_width_lp-1:0]      shift_r;
  logic [padded_width_lp-1:0]      shift_next;
  logic                            last_flit;
  logic                            v_r;
  payload_t                        packet_r;

  assign header = flit_i;

  // New flit enters at the top, so the first body flit ends at the bottom
  assign shift_next = (shift_r >> `MC_WH_FLIT_WIDTH)
                    | (padded_width_lp'(flit_i) << (padded_width_lp - `MC_WH_FLIT_WIDTH));

  assign last_flit = (state_r == body_s) && v_i && (cnt_r == 1);

  always_ff @(posedge mc_clk_i)
  begin
    if (reset_i)
    begin
      state_r <= idle_s;
      cnt_r   <= '0;
      v_r     <= 1'b0;
    end
    else
    begin
      v_r <= last_flit;
      case (state_r)
        idle_s:
        begin
          if (v_i)
          begin
            cnt_r   <= header.len;
            state_r <= body_s;
          end
        end
        body_s:
        begin
          if (v_i)
          begin
            cnt_r <= cnt_r - 1'b1;
            if (cnt_r == 1)
              state_r <= idle_s;
          end
        end
        default: state_r <= idle_s;
      endcase
    end
  end

  // Holding register and packet output
  always_ff @(posedge mc_clk_i)
  begin
    if ((state_r == body_s) && v_i)
      shift_r <= shift_next;
    if (last_flit)
      packet_r <= payload_t'(shift_next[payload_width_lp-1:0]);
  end

  assign v_o      = v_r;
  assign packet_o = packet_r;

  // Far-end packetizer must announce the body count of this payload type
  assert property (@(posedge mc_clk_i) disable iff (reset_i)
                   (state_r == idle_s && v_i) |-> (header.len == num_body_lp))
    else $error("wh_depacketizer: header len %0d, expected %0d", header.len, num_body_lp);

endmodule

// ==== verilog/mc_wh_link_adapter.sv ====
// Top level adapter between a manycore link and a wormhole network, one clock domain
`include "mc_wh_cfg.svh"

module mc_wh_link_adapter
  (input  logic                         mc_clk_i
  ,input  logic                         reset_i

  // Held stable while traffic flows
  ,input  logic [`MC_WH_CORD_WIDTH-1:0] mc_dest_cord_i

  // Manycore forward net
  ,input  logic                         mc_fwd_v_i
  ,input  mc_wh_pkg::mc_fwd_packet_t    mc_fwd_packet_i
  ,output logic                         mc_fwd_v_o
  ,output mc_wh_pkg::mc_fwd_packet_t    mc_fwd_packet_o

  // Manycore reverse net
  ,input  logic                         mc_rev_v_i
  ,input  mc_wh_pkg::mc_rev_packet_t    mc_rev_packet_i
  ,output logic                         mc_rev_v_o
  ,output mc_wh_pkg::mc_rev_packet_t    mc_rev_packet_o

  // Wormhole forward net
  ,output logic                         wh_fwd_v_o
  ,output logic [`MC_WH_FLIT_WIDTH-1:0] wh_fwd_flit_o
  ,input  logic                         wh_fwd_v_i
  ,input  logic [`MC_WH_FLIT_WIDTH-1:0] wh_fwd_flit_i

  // Wormhole reverse net
  ,output logic                         wh_rev_v_o
  ,output logic [`MC_WH_FLIT_WIDTH-1:0] wh_rev_flit_o
  ,input  logic                         wh_rev_v_i
  ,input  logic [`MC_WH_FLIT_WIDTH-1:0] wh_rev_flit_i
  );

  logic [`MC_WH_RESET_DEPTH-1:0] reset_r;
  logic                          engine_reset;

  // Reset pipeline, eases fanout to the engines
  always_ff @(posedge mc_clk_i)
  begin
    reset_r <= {reset_r[`MC_WH_RESET_DEPTH-2:0], reset_i};
  end

  assign engine_reset = reset_r[`MC_WH_RESET_DEPTH-1];

  // Forward net, manycore to wormhole
  wh_packetizer #(.payload_t(mc_wh_pkg::mc_fwd_packet_t)) fwd_tx
    (.mc_clk_i    (mc_clk_i)
    ,.reset_i     (engine_reset)
    ,.v_i         (mc_fwd_v_i)
    ,.packet_i    (mc_fwd_packet_i)
    ,.dest_cord_i (mc_dest_cord_i)
    ,.v_o         (wh_fwd_v_o)
    ,.flit_o      (wh_fwd_flit_o)
    );

  // Reverse net, manycore to wormhole
  wh_packetizer #(.payload_t(mc_wh_pkg::mc_rev_packet_t)) rev_tx
    (.mc_clk_i    (mc_clk_i)
    ,.reset_i     (engine_reset)
    ,.v_i         (mc_rev_v_i)
    ,.packet_i    (mc_rev_packet_i)
    ,.dest_cord_i (mc_dest_cord_i)
    ,.v_o         (wh_rev_v_o)
    ,.flit_o      (wh_rev_flit_o)
    );

  // Forward net, wormhole to manycore
  wh_depacketizer #(.payload_t(mc_wh_pkg::mc_fwd_packet_t)) fwd_rx
    (.mc_clk_i    (mc_clk_i)
    ,.reset_i     (engine_reset)
    ,.v_i         (wh_fwd_v_i)
    ,.flit_i      (wh_fwd_flit_i)
    ,.v_o         (mc_fwd_v_o)
    ,.packet_o    (mc_fwd_packet_o)
    );

  // Reverse net, wormhole to manycore
  wh_depacketizer #(.payload_t(mc_wh_pkg::mc_rev_packet_t)) rev_rx
    (.mc_clk_i    (mc_clk_i)
    ,.reset_i     (engine_reset)
    ,.v_i         (wh_rev_v_i)
    ,.flit_i      (wh_rev_flit_i)
    ,.v_o         (mc_rev_v_o)
    ,.packet_o    (mc_rev_packet_o)
    );

endmodule

// ==== dv/tb_mc_wh_link_adapter.sv ====
// Self-checking testbench for the link adapter; loops the wormhole side back on itself
`include "mc_wh_cfg.svh"

module tb_mc_wh_link_adapter;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_pkts_lp       = 200;
  localparam int timeout_cycles_lp = num_pkts_lp * 8 + 400;
  localparam int fwd_latency_lp    = 6;
  localparam int rev_latency_lp    = 5;

  // One expected flit with the cycle it should appear in
  typedef struct packed
  {
    logic [`MC_WH_FLIT_WIDTH-1:0] flit;
    logic [31:0]                  cyc;
    logic [3:0]                   idx;
  } exp_flit_t;

  logic                         mc_clk_i;
  logic                         reset_i;
  logic [`MC_WH_CORD_WIDTH-1:0] mc_dest_cord_i;
  logic                         mc_fwd_v_i;
  mc_wh_pkg::mc_fwd_packet_t    mc_fwd_packet_i;
  logic                         mc_fwd_v_o;
  mc_wh_pkg::mc_fwd_packet_t    mc_fwd_packet_o;
  logic                         mc_rev_v_i;
  mc_wh_pkg::mc_rev_packet_t    mc_rev_packet_i;
  logic                         mc_rev_v_o;
  mc_wh_pkg::mc_rev_packet_t    mc_rev_packet_o;
  logic                         wh_fwd_v_o;
  logic [`MC_WH_FLIT_WIDTH-1:0] wh_fwd_flit_o;
  logic                         wh_rev_v_o;
  logic [`MC_WH_FLIT_WIDTH-1:0] wh_rev_flit_o;

  exp_flit_t                 fwd_flit_q[$];
  exp_flit_t                 rev_flit_q[$];
  mc_wh_pkg::mc_fwd_packet_t fwd_pkt_q[$];
  mc_wh_pkg::mc_rev_packet_t rev_pkt_q[$];
  int                        fwd_sent_q[$];
  int                        rev_sent_q[$];

  int   cyc = 0;
  int   fwd_rx_count = 0;
  int   rev_rx_count = 0;
  int   reset_errs = 0;
  int   flit_errs = 0;
  int   pkt_errs = 0;
  int   end_errs = 0;
  int   timeouts = 0;
  logic traffic_started = 1'b0;
  logic [31:0] fwd_seed;
  logic [31:0] rev_seed;

  // Wormhole outputs feed straight back into the wormhole inputs
  mc_wh_link_adapter dut
    (.mc_clk_i        (mc_clk_i)
    ,.reset_i         (reset_i)
    ,.mc_dest_cord_i  (mc_dest_cord_i)
    ,.mc_fwd_v_i      (mc_fwd_v_i)
    ,.mc_fwd_packet_i (mc_fwd_packet_i)
    ,.mc_fwd_v_o      (mc_fwd_v_o)
    ,.mc_fwd_packet_o (mc_fwd_packet_o)
    ,.mc_rev_v_i      (mc_rev_v_i)
    ,.mc_rev_packet_i (mc_rev_packet_i)
    ,.mc_rev_v_o      (mc_rev_v_o)
    ,.mc_rev_packet_o (mc_rev_packet_o)
    ,.wh_fwd_v_o      (wh_fwd_v_o)
    ,.wh_fwd_flit_o   (wh_fwd_flit_o)
    ,.wh_fwd_v_i      (wh_fwd_v_o)
    ,.wh_fwd_flit_i   (wh_fwd_flit_o)
    ,.wh_rev_v_o      (wh_rev_v_o)
    ,.wh_rev_flit_o   (wh_rev_flit_o)
    ,.wh_rev_v_i      (wh_rev_v_o)
    ,.wh_rev_flit_i   (wh_rev_flit_o)
    );

  initial
  begin
    mc_clk_i = 1'b0;
    forever #50 mc_clk_i = ~mc_clk_i;
  end

  always @(posedge mc_clk_i)
  begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Header then body flits, payload least significant part first
  task automatic push_flits(input logic is_rev, input logic [63:0] bits,
                            input int width, input int send_cyc);
    int        num_body;
    exp_flit_t e;
    num_body = (width + `MC_WH_FLIT_WIDTH - 1) / `MC_WH_FLIT_WIDTH;
    e = '0;
    e.flit[`MC_WH_CORD_WIDTH-1:0] = mc_dest_cord_i;
    e.flit[`MC_WH_CORD_WIDTH +: `MC_WH_LEN_WIDTH] = num_body[`MC_WH_LEN_WIDTH-1:0];
    e.cyc = send_cyc + 1;
    for (int k = 0; k <= num_body; k++)
    begin
      if (k > 0)
      begin
        e.flit = bits[(k-1)*`MC_WH_FLIT_WIDTH +: `MC_WH_FLIT_WIDTH];
        e.cyc  = send_cyc + 1 + k;
      end
      e.idx = k[3:0];
      if (is_rev)
        rev_flit_q.push_back(e);
      else
        fwd_flit_q.push_back(e);
    end
  endtask

  task automatic fwd_stream();
    mc_wh_pkg::mc_fwd_packet_t pkt;
    int                        gap;
    for (int i = 0; i < num_pkts_lp; i++)
    begin
      fwd_seed  = lcg_next(fwd_seed);
      pkt.data  = fwd_seed;
      fwd_seed  = lcg_next(fwd_seed);
      pkt.addr  = fwd_seed[31:16];
      pkt.op    = fwd_seed[15:14];
      pkt.src_x = fwd_seed[13:10];
      pkt.src_y = fwd_seed[9:6];
      fwd_seed  = lcg_next(fwd_seed);
      gap       = 5 + int'(fwd_seed[31:30]);
      mc_fwd_v_i      = 1'b1;
      mc_fwd_packet_i = pkt;
      fwd_pkt_q.push_back(pkt);
      fwd_sent_q.push_back(cyc);
      push_flits(1'b0, 64'(pkt), $bits(pkt), cyc);
      @(negedge mc_clk_i);
      mc_fwd_v_i = 1'b0;
      repeat (gap - 1) @(negedge mc_clk_i);
    end
  endtask

  task automatic rev_stream();
    mc_wh_pkg::mc_rev_packet_t pkt;
    int                        gap;
    for (int i = 0; i < num_pkts_lp; i++)
    begin
      rev_seed = lcg_next(rev_seed);
      pkt.data = rev_seed;
      rev_seed = lcg_next(rev_seed);
      pkt.op   = rev_seed[31:30];
      gap      = 4 + int'(rev_seed[29:28]);
      mc_rev_v_i      = 1'b1;
      mc_rev_packet_i = pkt;
      rev_pkt_q.push_back(pkt);
      rev_sent_q.push_back(cyc);
      push_flits(1'b1, 64'(pkt), $bits(pkt), cyc);
      @(negedge mc_clk_i);
      mc_rev_v_i = 1'b0;
      repeat (gap - 1) @(negedge mc_clk_i);
    end
  endtask

  task automatic check_flit(input logic is_rev, input logic v,
                            input logic [`MC_WH_FLIT_WIDTH-1:0] flit);
    string     name;
    exp_flit_t e;
    name = is_rev ? "rev" : "fwd";
    if ((is_rev ? rev_flit_q.size() : fwd_flit_q.size()) == 0)
    begin
      if (v === 1'b1)
      begin
        $display("%s flit: unexpected flit %h at cycle %0d", name, flit, cyc);
        flit_errs++;
      end
      return;
    end
    e = is_rev ? rev_flit_q[0] : fwd_flit_q[0];
    if (v !== 1'b1 && int'(e.cyc) > cyc)
      return;
    if (is_rev)
      void'(rev_flit_q.pop_front());
    else
      void'(fwd_flit_q.pop_front());
    if (v !== 1'b1)
    begin
      $display("%s flit: flit %0d due at cycle %0d never came", name, e.idx, e.cyc);
      flit_errs++;
    end
    else if (int'(e.cyc) != cyc)
    begin
      $display("error %s flit %0d cycle: expected %0d, actual %0d", name, e.idx, e.cyc, cyc);
      flit_errs++;
    end
    else if (flit !== e.flit)
    begin
      $display("error %s %s %0d: expected %h, actual %h", name,
               (e.idx == 0) ? "header" : "body", e.idx, e.flit, flit);
      flit_errs++;
    end
  endtask

  task automatic check_fwd_packet();
    mc_wh_pkg::mc_fwd_packet_t exp_pkt;
    int                        sent;
    if (mc_fwd_v_o !== 1'b1)
    begin
      if (fwd_sent_q.size() != 0 && fwd_sent_q[0] + fwd_latency_lp < cyc)
      begin
        $display("fwd round trip: packet sent at cycle %0d never came out", fwd_sent_q[0]);
        pkt_errs++;
        void'(fwd_pkt_q.pop_front());
        void'(fwd_sent_q.pop_front());
      end
      return;
    end
    fwd_rx_count++;
    if (fwd_pkt_q.size() == 0)
    begin
      $display("fwd round trip: unexpected packet at cycle %0d", cyc);
      pkt_errs++;
      return;
    end
    exp_pkt = fwd_pkt_q.pop_front();
    sent    = fwd_sent_q.pop_front();
    if (mc_fwd_packet_o !== exp_pkt)
    begin
      $display("error fwd round trip: expected %h, actual %h", exp_pkt, mc_fwd_packet_o);
      pkt_errs++;
    end
    if (cyc - sent != fwd_latency_lp)
    begin
      $display("error fwd latency: expected %0d, actual %0d", fwd_latency_lp, cyc - sent);
      pkt_errs++;
    end
  endtask

  task automatic check_rev_packet();
    mc_wh_pkg::mc_rev_packet_t exp_pkt;
    int                        sent;
    if (mc_rev_v_o !== 1'b1)
    begin
      if (rev_sent_q.size() != 0 && rev_sent_q[0] + rev_latency_lp < cyc)
      begin
        $display("rev round trip: packet sent at cycle %0d never came out", rev_sent_q[0]);
        pkt_errs++;
        void'(rev_pkt_q.pop_front());
        void'(rev_sent_q.pop_front());
      end
      return;
    end
    rev_rx_count++;
    if (rev_pkt_q.size() == 0)
    begin
      $display("rev round trip: unexpected packet at cycle %0d", cyc);
      pkt_errs++;
      return;
    end
    exp_pkt = rev_pkt_q.pop_front();
    sent    = rev_sent_q.pop_front();
    if (mc_rev_packet_o !== exp_pkt)
    begin
      $display("error rev round trip: expected %h, actual %h", exp_pkt, mc_rev_packet_o);
      pkt_errs++;
    end
    if (cyc - sent != rev_latency_lp)
    begin
      $display("error rev latency: expected %0d, actual %0d", rev_latency_lp, cyc - sent);
      pkt_errs++;
    end
  endtask

  // Outputs are sampled halfway through the cycle
  always @(negedge mc_clk_i)
  begin
    if (!traffic_started && (wh_fwd_v_o === 1'b1 || wh_rev_v_o === 1'b1
                             || mc_fwd_v_o === 1'b1 || mc_rev_v_o === 1'b1))
    begin
      $display("reset: a valid output is high at cycle %0d before traffic", cyc);
      reset_errs++;
    end
    check_flit(1'b0, wh_fwd_v_o, wh_fwd_flit_o);
    check_flit(1'b1, wh_rev_v_o, wh_rev_flit_o);
    check_fwd_packet();
    check_rev_packet();
  end

  task automatic finish_run();
    $display("Errors: reset %0d, flit %0d, packet %0d, completion %0d, timeout %0d",
             reset_errs, flit_errs, pkt_errs, end_errs, timeouts);
    if (reset_errs + flit_errs + pkt_errs + end_errs + timeouts == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  endtask

  initial
  begin
    while (cyc < timeout_cycles_lp)
      @(posedge mc_clk_i);
    $display("Timeout: traffic did not finish within %0d cycles", timeout_cycles_lp);
    timeouts = 1;
    finish_run();
  end

  initial
  begin
    fwd_seed        = 32'd55530;
    rev_seed        = 32'd55530 ^ 32'ha5a5_0000;
    fwd_seed        = lcg_next(fwd_seed);
    reset_i         = 1'b1;
    mc_dest_cord_i  = fwd_seed[31:24];
    mc_fwd_v_i      = 1'b0;
    mc_fwd_packet_i = '0;
    mc_rev_v_i      = 1'b0;
    mc_rev_packet_i = '0;
    // Strobes offered once reset reaches the engines must be ignored
    repeat (`MC_WH_RESET_DEPTH) @(posedge mc_clk_i);
    @(negedge mc_clk_i);
    mc_fwd_v_i = 1'b1;
    mc_rev_v_i = 1'b1;
    repeat (10 - `MC_WH_RESET_DEPTH) @(posedge mc_clk_i);
    @(negedge mc_clk_i);
    reset_i = 1'b0;
    // Engines stay in reset while the pipeline drains
    repeat (`MC_WH_RESET_DEPTH) @(posedge mc_clk_i);
    @(negedge mc_clk_i);
    traffic_started = 1'b1;
    mc_fwd_v_i      = 1'b0;
    mc_rev_v_i      = 1'b0;
    fork
      fwd_stream();
      rev_stream();
    join
    wait (fwd_rx_count >= num_pkts_lp && rev_rx_count >= num_pkts_lp);
    repeat (4) @(negedge mc_clk_i);
    if (fwd_pkt_q.size() != 0 || rev_pkt_q.size() != 0
        || fwd_flit_q.size() != 0 || rev_flit_q.size() != 0)
    begin
      $display("completion: expected packets or flits are still outstanding");
      end_errs++;
    end
    if (fwd_rx_count != num_pkts_lp || rev_rx_count != num_pkts_lp)
    begin
      $display("error completion count: expected %0d, actual fwd %0d rev %0d",
               num_pkts_lp, fwd_rx_count, rev_rx_count);
      end_errs++;
    end
    finish_run();
  end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/mc_wh_pkg.sv
verilog/wh_packetizer.sv
verilog/wh_depacketizer.sv
verilog/mc_wh_link_adapter.sv
dv/tb_mc_wh_link_adapter.sv

// ==== Makefile ====
# Verilator build and run for the manycore-to-wormhole link adapter

VERILATOR ?= verilator
TOP       ?= tb_mc_wh_link_adapter
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/mc_wh_cfg.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Simulation PASSED'

clean:
	rm -rf $(BUILD_DIR)
